// File: sources.f
+incdir+design
design/logger_pkg.sv
design/stream_pkg.sv
design/change_capture.sv
design/stream_fifo.sv
design/width_downsizer.sv
design/change_logger.sv
dv/change_logger_tb.sv

// File: Makefile
TOP := change_logger_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test passed"

obj_dir/V$(TOP): sources.f $(wildcard design/*.sv design/*.svh dv/*.sv)
	verilator --binary --timing -f sources.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/change_logger_tb.sv
`timescale 1ns/1ps
`include "logger_config.svh"

module change_logger_tb;

  import logger_pkg::*;

  localparam int BP_CHANGES      = 30;
  localparam int NUM_EVENTS      = 1 + 1 + 24 + BP_CHANGES;  // Changes driven over all tests
  localparam int WATCHDOG_CYCLES = 20 * NUM_EVENTS + 400;
  localparam int REC_BYTES       = `LOG_REC_WIDTH / `LOG_BYTE_WIDTH;

  logic                             clock;
  logic                             reset;
  logic                             enable_i;
  sig_t                             sig_i;
  ctx_t                             ctx_i;
  logic                             m_ready_i;
  logic [$clog2(`LOG_FIFO_DEPTH):0] level_o;
  logic                             dropped_o;
  logic                             m_valid_o;
  logic [`LOG_BYTE_WIDTH-1:0]       m_data_o;
  logic                             m_last_o;

  // Reference model
  sig_t                      prev_sig;
  logic [`LOG_REC_WIDTH-1:0] pend_rec;
  logic                      pending;     // Event seen and waiting for the drop verdict
  int                        rec_count;
  logic [8:0]                exp_q[$];    // {last, data}
  int                        out_count;
  int                        last_pos[$];
  logic [31:0]               lfsr_state;

  change_logger u_dut (
    .clock     (clock),
    .reset     (reset),
    .enable_i  (enable_i),
    .sig_i     (sig_i),
    .ctx_i     (ctx_i),
    .level_o   (level_o),
    .dropped_o (dropped_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_data_o  (m_data_o),
    .m_last_o  (m_last_o)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s at %0t", msg, $time);
      stop_on_error();
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  task automatic append_record(input logic [`LOG_REC_WIDTH-1:0] rec);
    logic last_byte;
    rec_count = (rec_count + 1) % `LOG_PACKET_SIZE;
    for (int b = 0; b < REC_BYTES; b++) begin
      last_byte = (b == REC_BYTES - 1) && (rec_count == 0);  // Eighth record ends a packet
      exp_q.push_back({last_byte, rec[`LOG_BYTE_WIDTH*b +: `LOG_BYTE_WIDTH]});
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      prev_sig  = '0;
      pending   = 1'b0;
      rec_count = 0;
      out_count = 0;
      exp_q.delete();
      last_pos.delete();
    end else begin
      if (m_valid_o && m_ready_i) begin
        expect_true(exp_q.size() != 0, "Output byte arrived while none was expected");
        expect_equal("m_data_o", 32'(exp_q[0][7:0]), 32'(m_data_o));
        expect_equal("m_last_o", 32'(exp_q[0][8]), 32'(m_last_o));
        out_count++;
        if (m_last_o) last_pos.push_back(out_count);
        void'(exp_q.pop_front());
      end
      if (pending && !dropped_o) append_record(pend_rec);  // Dropped records never count
      pending  = enable_i && (sig_i != prev_sig);
      pend_rec = {ctx_i, sig_i};
      if (enable_i) prev_sig = sig_i;
    end
  end

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic drive_sample(input logic en, input sig_t sig, input ctx_t ctx);
    @(posedge clock);
    enable_i <= en;
    sig_i    <= sig;
    ctx_i    <= ctx;
  endtask

  task automatic drive_random_change(inout sig_t prev);
    sig_t new_sig;
    new_sig = sig_t'(random_bits(`LOG_SIG_WIDTH));
    if (new_sig == prev) new_sig[0] = ~new_sig[0];  // Force a change
    prev = new_sig;
    drive_sample(1'b1, new_sig, ctx_t'(random_bits(`LOG_CTX_WIDTH)));
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    @(posedge clock);  // Let the last driven sample reach its event edge
    do begin
      @(negedge clock);
      cycles++;
    end while ((exp_q.size() != 0 || pending || m_valid_o) && cycles < 500);
    expect_true(cycles < 500, "Output stream did not drain in time");
  endtask

  task automatic check_reset();
    @(negedge clock);
    expect_equal("m_valid_o", 0, 32'(m_valid_o));
    expect_equal("dropped_o", 0, 32'(dropped_o));
    expect_equal("level_o", 0, 32'(level_o));
  endtask

  task automatic check_single_change();
    int start_count;
    start_count = out_count;
    drive_sample(1'b1, 16'h1234, 16'hABCD);
    @(posedge clock);  // Event edge
    repeat (2) begin
      @(negedge clock);
      expect_equal("m_valid_o", 0, 32'(m_valid_o));
    end
    @(negedge clock);
    expect_equal("m_valid_o", 1, 32'(m_valid_o));  // First byte in the third cycle
    wait_drained();
    expect_equal("byte count", 4, out_count - start_count);
    expect_equal("last count", 0, last_pos.size());
  endtask

  task automatic check_enable_and_repeat();
    int start_count;
    start_count = out_count;
    drive_sample(1'b0, 16'h5555, 16'h0101);
    drive_sample(1'b0, 16'h6666, 16'h0202);
    drive_sample(1'b1, 16'h1234, 16'h0303);  // Same as the last enabled sample
    drive_sample(1'b1, 16'h1234, 16'h0404);
    repeat (6) @(negedge clock);
    expect_equal("byte count", 0, out_count - start_count);
    drive_sample(1'b1, 16'h4321, 16'h0505);
    wait_drained();
    expect_equal("byte count", 4, out_count - start_count);
  endtask

  task automatic check_packet_last();
    sig_t prev;
    drive_sample(1'b0, sig_i, ctx_i);
    apply_reset();  // Packet count starts again from zero
    prev = '0;
    repeat (24) begin
      drive_random_change(prev);
      repeat (3) @(posedge clock);  // Records no faster than their bytes leave
    end
    wait_drained();
    expect_equal("last count", 3, last_pos.size());
    for (int i = 0; i < last_pos.size(); i++) begin
      expect_equal("last position", 32 * (i + 1), last_pos[i]);
    end
  endtask

  task automatic check_backpressure();
    sig_t prev;
    logic dropped_seen;
    int   cycles;
    prev         = sig_i;
    dropped_seen = 1'b0;
    cycles       = 0;
    @(posedge clock);
    m_ready_i <= 1'b0;
    repeat (BP_CHANGES) begin
      drive_random_change(prev);
      @(negedge clock);
      expect_true(32'(level_o) <= `LOG_FIFO_DEPTH, "FIFO level went above its depth");
      if (dropped_o) begin
        dropped_seen = 1'b1;
        expect_equal("level_o", `LOG_FIFO_DEPTH, 32'(level_o));  // Drops only when full
      end
    end
    expect_true(dropped_seen, "No drop was reported with the path full");
    do begin
      @(posedge clock);
      m_ready_i <= (random_bits(2) != 32'd0);  // Stall about one cycle in four
      @(negedge clock);
      expect_true(32'(level_o) <= `LOG_FIFO_DEPTH, "FIFO level went above its depth");
      cycles++;
    end while (exp_q.size() != 0 && cycles < 1000);
    @(posedge clock);
    m_ready_i <= 1'b1;
    wait_drained();
  endtask

  initial begin
    lfsr_state = 32'h7add_ba80;
    enable_i  <= 1'b0;
    sig_i     <= '0;
    ctx_i     <= '0;
    m_ready_i <= 1'b1;
    apply_reset();
    check_reset();
    check_single_change();
    check_enable_and_repeat();
    check_packet_last();
    check_backpressure();
    @(negedge clock);
    if (exp_q.size() == 0 && !pending) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Expected bytes were never sent");
      stop_on_error();
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    stop_on_error();
  end

endmodule

// File: design/change_logger.sv
`timescale 1ns/1ps
`include "logger_config.svh"

module change_logger (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             enable_i,
  input  logic [`LOG_SIG_WIDTH-1:0]        sig_i,
  input  logic [`LOG_CTX_WIDTH-1:0]        ctx_i,
  output logic [$clog2(`LOG_FIFO_DEPTH):0] level_o,
  output logic                             dropped_o,
  output logic                             m_valid_o,
  input  logic                             m_ready_i,
  output logic [`LOG_BYTE_WIDTH-1:0]       m_data_o,
  output logic                             m_last_o
);

  import stream_pkg::*;

  rec_beat_t  cap_beat;
  rec_beat_t  fifo_beat;
  byte_beat_t out_beat;
  logic       cap_valid;
  logic       cap_ready;
  logic       fifo_valid;
  logic       fifo_ready;

  change_capture u_capture (
    .clock       (clock),
    .reset       (reset),
    .enable_i    (enable_i),
    .sig_i       (sig_i),
    .ctx_i       (ctx_i),
    .rec_valid_o (cap_valid),
    .rec_ready_i (cap_ready),
    .rec_o       (cap_beat),
    .dropped_o   (dropped_o)
  );

  stream_fifo #(
    .payload_t (rec_beat_t),
    .DEPTH     (`LOG_FIFO_DEPTH)
  ) u_fifo (
    .clock      (clock),
    .reset      (reset),
    .wr_valid_i (cap_valid),
    .wr_ready_o (cap_ready),
    .wr_data_i  (cap_beat),
    .rd_valid_o (fifo_valid),
    .rd_ready_i (fifo_ready),
    .rd_data_o  (fifo_beat),
    .level_o    (level_o)    // Occupancy status
  );

  width_downsizer u_downsizer (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (fifo_valid),
    .s_ready_o (fifo_ready),
    .s_beat_i  (fifo_beat),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_beat_o  (out_beat)
  );

  assign m_data_o = out_beat.data;
  assign m_last_o = out_beat.last;

endmodule

// File: design/width_downsizer.sv
`timescale 1ns/1ps
`include "logger_config.svh"

module width_downsizer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  input  stream_pkg::rec_beat_t  s_beat_i,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  output stream_pkg::byte_beat_t m_beat_o
);

  localparam int NUM_BYTES = `LOG_REC_WIDTH / `LOG_BYTE_WIDTH;
  localparam int IDX_W     = $clog2(NUM_BYTES);

  logic [`LOG_REC_WIDTH-1:0] shift_q;  // Next byte to send sits at the bottom
  logic                      last_q;
  logic                      full_q;
  logic [IDX_W-1:0]          idx_q;
  logic                      final_byte;
  logic                      take;
  logic                      send;

  assign final_byte = (idx_q == IDX_W'(NUM_BYTES - 1));
  assign send       = full_q && m_ready_i;

  // Reload on the final byte's transfer keeps the output free of gaps
  assign s_ready_o  = !full_q || (m_ready_i && final_byte);
  assign take       = s_valid_i && s_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (take) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (send) begin
      idx_q <= idx_q + 1'b1;
      if (final_byte) full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      shift_q <= s_beat_i.rec;
      last_q  <= s_beat_i.last;
    end else if (send) begin
      shift_q <= shift_q >> `LOG_BYTE_WIDTH;  // Least significant byte first
    end
  end

  assign m_valid_o     = full_q;
  assign m_beat_o.data = shift_q[`LOG_BYTE_WIDTH-1:0];
  assign m_beat_o.last = last_q && final_byte;  // Packet end on byte 3 only

endmodule

// File: design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     wr_valid_i,
  output logic                     wr_ready_o,
  input  payload_t                 wr_data_i,
  output logic                     rd_valid_o,
  input  logic                     rd_ready_i,
  output payload_t                 rd_data_o,
  output logic [$clog2(DEPTH):0]   level_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH) + 1;

  payload_t               mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [LVL_W-1:0]       count_q;
  logic                   wr_en;
  logic                   rd_en;

  // Wraps explicitly so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign wr_ready_o = (count_q != LVL_W'(DEPTH));  // Low only when full
  assign rd_valid_o = (count_q != '0);
  assign wr_en      = wr_valid_i && wr_ready_o;
  assign rd_en      = rd_valid_o && rd_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (rd_en) rd_ptr_q <= next_ptr(rd_ptr_q);

      // Simultaneous read and write leaves the count unchanged
      if (wr_en && !rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_ptr_q] <= wr_data_i;
  end

  // Head entry comes straight from the storage registers
  assign rd_data_o = mem[rd_ptr_q];
  assign level_o   = count_q;

endmodule

// File: design/change_capture.sv
`timescale 1ns/1ps
`include "logger_config.svh"

module change_capture (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      enable_i,
  input  logic [`LOG_SIG_WIDTH-1:0] sig_i,
  input  logic [`LOG_CTX_WIDTH-1:0] ctx_i,
  output logic                      rec_valid_o,
  input  logic                      rec_ready_i,
  output stream_pkg::rec_beat_t     rec_o,
  output logic                      dropped_o
);

  import logger_pkg::*;
  import stream_pkg::*;

  sig_t       prev_q;
  pkt_count_t count_q;
  record_t    rec_d;
  logic       valid_q;
  logic       dropped_q;
  logic       event_d;
  logic       load_d;
  logic       last_d;

  assign event_d = enable_i && (sig_i != prev_q);
  // Register is free when empty or handing its record over on this edge
  assign load_d  = event_d && (!valid_q || rec_ready_i);
  assign last_d  = (count_q == pkt_count_t'(`LOG_PACKET_SIZE - 1));

  assign rec_d.ctx = ctx_i;
  assign rec_d.sig = sig_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      prev_q    <= '0;
      count_q   <= '0;
      valid_q   <= 1'b0;
      dropped_q <= 1'b0;
    end else begin
      if (enable_i) prev_q <= sig_i;  // Every enabled sample, changed or not
      if (load_d) begin
        valid_q <= 1'b1;
        count_q <= last_d ? '0 : count_q + 1'b1;
      end else if (rec_ready_i) begin
        valid_q <= 1'b0;
      end
      dropped_q <= event_d && !load_d;  // Only loaded records count
    end
  end

  always_ff @(posedge clock) begin
    if (load_d) begin
      rec_o.rec  <= rec_d;
      rec_o.last <= last_d;
    end
  end

  assign rec_valid_o = valid_q;
  assign dropped_o   = dropped_q;

endmodule

// File: design/stream_pkg.sv
`include "logger_config.svh"

package stream_pkg;

  import logger_pkg::*;

  typedef logic [`LOG_BYTE_WIDTH-1:0] byte_t;

  // Record side of the stream, one record per beat
  typedef struct packed {
    record_t rec;
    logic    last;  // End of packet
  } rec_beat_t;

  // Byte side of the stream
  typedef struct packed {
    byte_t data;
    logic  last;  // Only on the final byte of a packet
  } byte_beat_t;

endpackage

// File: design/logger_pkg.sv
`include "logger_config.svh"

package logger_pkg;

  // Raw sample of the watched signal
  typedef logic [`LOG_SIG_WIDTH-1:0] sig_t;

  // Context bits captured next to each sample
  typedef logic [`LOG_CTX_WIDTH-1:0] ctx_t;

  // Position of a record inside its packet
  typedef logic [$clog2(`LOG_PACKET_SIZE)-1:0] pkt_count_t;

  // Captured record, context in the upper half
  typedef struct packed {
    ctx_t ctx;
    sig_t sig;
  } record_t;

endpackage

// File: design/logger_config.svh
`ifndef LOGGER_CONFIG_SVH
`define LOGGER_CONFIG_SVH

// Watched signal, compared against the previous enabled sample
`define LOG_SIG_WIDTH 16

// Context bits, carried along but never compared
`define LOG_CTX_WIDTH 16

// One record holds the context above the signal
`define LOG_REC_WIDTH (`LOG_CTX_WIDTH + `LOG_SIG_WIDTH)

// Record FIFO entries
`define LOG_FIFO_DEPTH 16

// Records per packet, the last one carries the end-of-packet flag
`define LOG_PACKET_SIZE 8

// Output stream beat width
`define LOG_BYTE_WIDTH 8

`endif
